/* common/fix_pkg.sv */
// FIX message format definitions
`default_nettype none

package fix_pkg;

	////////////////////////////////////////////////////////////
	// Trailer byte values
	////////////////////////////////////////////////////////////

	localparam logic [7:0] SOH_CHAR  = 8'h01;
	localparam logic [7:0] TAG_ONE   = 8'h31;	// '1'
	localparam logic [7:0] TAG_ZERO  = 8'h30;	// '0'
	localparam logic [7:0] TAG_EQ    = 8'h3d;	// '='
	localparam logic [7:0] ZERO_CHAR = 8'h30;	// Base of the digit range

	localparam int CKSUM_DIGITS = 3;	// Digits after "10="

	////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////

	typedef logic [7:0] byte_t;
	typedef logic [7:0] cksum_t;	// Sum modulo 256
	typedef logic [9:0] rcv_val_t;	// Three decimal digits, up to 999

endpackage

`default_nettype wire

/* common/cksum_cfg_pkg.sv */
// Checksum subsystem configuration
`default_nettype none

package cksum_cfg_pkg;

	////////////////////////////////////////////////////////////
	// Lane array
	////////////////////////////////////////////////////////////

	localparam int LANES = 4;	// Power of two, the pointers wrap

	typedef logic [$clog2(LANES)-1:0] lane_idx_t;

	////////////////////////////////////////////////////////////
	// Verdict and lane FSM encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OK         = 2'd0,
		BAD_SUM    = 2'd1,	// Digits decode to a different value
		BAD_FORMAT = 2'd2	// Non-digit or missing closing SOH
	} status_e;

	typedef enum logic [2:0] {
		L_IDLE   = 3'd0,
		L_SUM    = 3'd1,	// Summing body bytes, watching for the trailer
		L_DIGITS = 3'd2,
		L_TERM   = 3'd3,	// Waiting for the closing SOH
		L_HOLD   = 3'd4
	} lane_state_e;

endpackage

`default_nettype wire

/* common/lane_ifs.sv */
// Lane byte and result interfaces
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////
// Byte path from dispatcher to one lane
////////////////////////////////////////////////////////////

interface lane_byte_if;
	import fix_pkg::*;

	logic  stb;	// One cycle per byte
	byte_t dat;
	logic  sof;
	logic  busy;	// Lane owns a message or an uncollected result

	modport dispatch (
		output stb,
		output dat,
		output sof,
		input  busy
	);

	modport lane (
		input  stb,
		input  dat,
		input  sof,
		output busy
	);

endinterface

////////////////////////////////////////////////////////////
// Result path from one lane to the collector
////////////////////////////////////////////////////////////

interface lane_result_if;
	import fix_pkg::*;
	import cksum_cfg_pkg::*;

	logic     done;
	cksum_t   cksum;
	rcv_val_t rcv;
	status_e  status;
	logic     take;	// Release strobe from the collector

	modport lane (
		output done,
		output cksum,
		output rcv,
		output status,
		input  take
	);

	modport collect (
		input  done,
		input  cksum,
		input  rcv,
		input  status,
		output take
	);

endinterface

`default_nettype wire

/* rtl/msg_dispatch.sv */
// Message dispatcher
`timescale 1ns/1ns
`default_nettype none

module msg_dispatch (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  byte_req_i,
	input  logic                  sof_i,
	input  fix_pkg::byte_t        byte_i,
	output logic                  byte_ack_o,
	lane_byte_if.dispatch         lane_o [cksum_cfg_pkg::LANES]
);
	import fix_pkg::*;
	import cksum_cfg_pkg::*;

	typedef enum logic [1:0] {
		WAIT_REQ,
		ACK,		// Ack just raised, strobe in flight
		WAIT_DROP
	} disp_state_e;

	disp_state_e      state_q;
	lane_idx_t        cur_lane;
	lane_idx_t        nxt_lane;
	logic             started;	// A start flag has been seen since reset
	logic [LANES-1:0] stb_q;
	logic [LANES-1:0] busy_vec;
	byte_t            dat_q;
	logic             sof_q;

	// First message goes to lane 0, each later one to the following lane
	assign nxt_lane = started ? cur_lane + lane_idx_t'(1) : cur_lane;

	for (genvar g = 0; g < LANES; g++) begin : g_lane_port
		assign lane_o[g].stb = stb_q[g];
		assign lane_o[g].dat = dat_q;
		assign lane_o[g].sof = sof_q;
		assign busy_vec[g]   = lane_o[g].busy;
	end

	////////////////////////////////////////////////////////////
	// Input handshake and steering
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		stb_q <= '0;
		if (rst) begin
			state_q    <= WAIT_REQ;
			byte_ack_o <= 1'b0;
			cur_lane   <= '0;
			started    <= 1'b0;
		end else begin
			case (state_q)
				WAIT_REQ: begin
					if (byte_req_i && sof_i) begin
						if (!busy_vec[nxt_lane]) begin	// Stall while the lane is busy
							cur_lane        <= nxt_lane;
							started         <= 1'b1;
							stb_q[nxt_lane] <= 1'b1;
							byte_ack_o      <= 1'b1;
							state_q         <= ACK;
						end
					end else if (byte_req_i) begin
						if (started)
							stb_q[cur_lane] <= 1'b1;	// Stray bytes are only acked
						byte_ack_o <= 1'b1;
						state_q    <= ACK;
					end
				end
				ACK: begin
					if (!byte_req_i) begin
						byte_ack_o <= 1'b0;
						state_q    <= WAIT_REQ;
					end else begin
						state_q <= WAIT_DROP;
					end
				end
				WAIT_DROP: begin
					if (!byte_req_i) begin
						byte_ack_o <= 1'b0;
						state_q    <= WAIT_REQ;
					end
				end
				default: state_q <= WAIT_REQ;
			endcase
		end
	end

	// Byte is captured with the strobe since the source may move on after ack
	always_ff @(posedge clk) begin
		if (state_q == WAIT_REQ && byte_req_i) begin
			dat_q <= byte_i;
			sof_q <= sof_i;
		end
	end

endmodule

`default_nettype wire

/* cksum_lane/ascii_dec_field.sv */
// ASCII decimal field decoder
`timescale 1ns/1ns
`default_nettype none

module ascii_dec_field (
	input  logic              clk,
	input  logic              rst,
	input  logic              clear_i,
	input  logic              dig_stb_i,
	input  fix_pkg::byte_t    dig_i,
	output fix_pkg::rcv_val_t value_o,
	output logic              bad_o,
	output logic              full_o
);
	import fix_pkg::*;

	localparam int CNT_W = $clog2(CKSUM_DIGITS + 1);

	logic [CNT_W-1:0] cnt_q;
	logic             bad_q;	// Sticky until the next clear
	rcv_val_t         value_q;
	byte_t            offset;
	logic             is_dig;

	// Bytes below '0' wrap to large values
	assign offset = dig_i - ZERO_CHAR;
	assign is_dig = (offset < 8'd10);

	assign full_o  = (cnt_q == CNT_W'(CKSUM_DIGITS));
	assign bad_o   = bad_q || (dig_stb_i && !is_dig);	// Includes the byte on the input now
	assign value_o = value_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q <= '0;
			bad_q <= 1'b0;
		end else if (clear_i) begin
			cnt_q <= '0;
			bad_q <= 1'b0;
		end else if (dig_stb_i && !full_o) begin
			cnt_q <= cnt_q + CNT_W'(1);
			if (!is_dig)
				bad_q <= 1'b1;
		end
	end

	// Horner step, value = 10 * value + digit
	always_ff @(posedge clk) begin
		if (clear_i)
			value_q <= '0;
		else if (dig_stb_i && !full_o && is_dig && !bad_q)
			value_q <= value_q * rcv_val_t'(10) + rcv_val_t'(offset);
	end

endmodule

`default_nettype wire

/* cksum_lane/cksum_lane.sv */
// Checksum lane
`timescale 1ns/1ns
`default_nettype none

module cksum_lane (
	input  logic          clk,
	input  logic          rst,
	lane_byte_if.lane     byte_in,
	lane_result_if.lane   res_out
);
	import fix_pkg::*;
	import cksum_cfg_pkg::*;

	lane_state_e state_q;
	byte_t       win_q [0:2];	// Three previous bytes, index 0 newest
	cksum_t      sum_q;
	status_e     status_q;
	logic        trailer_hit;

	logic        dec_clear;
	logic        dec_stb;
	rcv_val_t    dec_value;
	logic        dec_bad;
	logic        dec_full;

	// Window plus incoming byte spells SOH "10="
	assign trailer_hit = (win_q[2] == SOH_CHAR) && (win_q[1] == TAG_ONE) &&
	                     (win_q[0] == TAG_ZERO) && (byte_in.dat == TAG_EQ);

	assign dec_clear = byte_in.stb && (state_q == L_IDLE);
	assign dec_stb   = byte_in.stb && (state_q == L_DIGITS);

	ascii_dec_field i_dec (
		.clk       (clk),
		.rst       (rst),
		.clear_i   (dec_clear),
		.dig_stb_i (dec_stb),
		.dig_i     (byte_in.dat),
		.value_o   (dec_value),
		.bad_o     (dec_bad),
		.full_o    (dec_full)
	);

	////////////////////////////////////////////////////////////
	// Lane FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= L_IDLE;
		end else begin
			case (state_q)
				L_IDLE:
					if (byte_in.stb && byte_in.sof)
						state_q <= L_SUM;
				L_SUM:
					if (byte_in.stb && trailer_hit)
						state_q <= L_DIGITS;
				L_DIGITS: begin
					if (dec_stb && dec_bad)
						state_q <= L_HOLD;	// Abort on the first bad digit
					else if (dec_full)
						state_q <= L_TERM;
				end
				L_TERM:
					if (byte_in.stb)
						state_q <= L_HOLD;
				L_HOLD:
					if (res_out.take)
						state_q <= L_IDLE;
				default: state_q <= L_IDLE;
			endcase
		end
	end

	// Running sum, a byte counts once it drops out of the window
	always_ff @(posedge clk) begin
		if (state_q == L_IDLE && byte_in.stb && byte_in.sof) begin
			win_q[0] <= byte_in.dat;
			win_q[1] <= '0;
			win_q[2] <= '0;
			sum_q    <= '0;
		end else if (state_q == L_SUM && byte_in.stb) begin
			win_q[0] <= byte_in.dat;
			win_q[1] <= win_q[0];
			win_q[2] <= win_q[1];
			sum_q    <= sum_q + win_q[2];	// SOH leaves as '=' arrives
		end
	end

	// Verdict
	always_ff @(posedge clk) begin
		if (state_q == L_DIGITS && dec_stb && dec_bad) begin
			status_q <= BAD_FORMAT;
		end else if (state_q == L_TERM && byte_in.stb) begin
			if (byte_in.dat != SOH_CHAR)
				status_q <= BAD_FORMAT;
			else if (dec_value != rcv_val_t'(sum_q))
				status_q <= BAD_SUM;
			else
				status_q <= OK;
		end
	end

	assign byte_in.busy   = (state_q != L_IDLE);
	assign res_out.done   = (state_q == L_HOLD);
	assign res_out.cksum  = sum_q;
	assign res_out.rcv    = dec_value;
	assign res_out.status = status_q;

endmodule

`default_nettype wire

/* rtl/result_collect.sv */
// In-order result collector
`timescale 1ns/1ns
`default_nettype none

module result_collect (
	input  logic                   clk,
	input  logic                   rst,
	lane_result_if.collect         lane_i [cksum_cfg_pkg::LANES],
	input  logic                   res_ack_i,
	output logic                   res_req_o,
	output fix_pkg::cksum_t        cksum_o,
	output fix_pkg::rcv_val_t      rcv_o,
	output cksum_cfg_pkg::status_e status_o
);
	import fix_pkg::*;
	import cksum_cfg_pkg::*;

	typedef enum logic [1:0] {
		C_WAIT,
		C_REQ,
		C_DROP
	} coll_state_e;

	coll_state_e      state_q;
	lane_idx_t        rd_ptr;	// Follows the dispatch order
	logic [LANES-1:0] take_q;
	logic [LANES-1:0] done_vec;
	cksum_t           cksum_arr  [LANES];
	rcv_val_t         rcv_arr    [LANES];
	status_e          status_arr [LANES];

	for (genvar g = 0; g < LANES; g++) begin : g_lane_port
		assign done_vec[g]   = lane_i[g].done;
		assign cksum_arr[g]  = lane_i[g].cksum;
		assign rcv_arr[g]    = lane_i[g].rcv;
		assign status_arr[g] = lane_i[g].status;
		assign lane_i[g].take = take_q[g];
	end

	////////////////////////////////////////////////////////////
	// Output handshake
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		take_q <= '0;
		if (rst) begin
			state_q   <= C_WAIT;
			rd_ptr    <= '0;
			res_req_o <= 1'b0;
		end else begin
			case (state_q)
				C_WAIT:
					if (done_vec[rd_ptr]) begin
						res_req_o <= 1'b1;
						state_q   <= C_REQ;
					end
				C_REQ:
					if (res_ack_i) begin
						res_req_o      <= 1'b0;
						take_q[rd_ptr] <= 1'b1;	// Frees the lane
						state_q        <= C_DROP;
					end
				C_DROP:
					if (!res_ack_i) begin
						rd_ptr  <= rd_ptr + lane_idx_t'(1);
						state_q <= C_WAIT;
					end
				default: state_q <= C_WAIT;
			endcase
		end
	end

	// Presented result, held while res_req_o is high
	always_ff @(posedge clk) begin
		if (state_q == C_WAIT && done_vec[rd_ptr]) begin
			cksum_o  <= cksum_arr[rd_ptr];
			rcv_o    <= rcv_arr[rd_ptr];
			status_o <= status_arr[rd_ptr];
		end
	end

endmodule

`default_nettype wire

/* rtl/fix_cksum_top.sv */
// FIX checksum checker top
`timescale 1ns/1ns
`default_nettype none

module fix_cksum_top (
	input  logic                   clk,
	input  logic                   rst,

	// Byte input, four-phase
	input  logic                   byte_req_i,
	input  fix_pkg::byte_t         byte_i,
	input  logic                   sof_i,
	output logic                   byte_ack_o,

	// Result output, four-phase
	output logic                   res_req_o,
	output fix_pkg::cksum_t        cksum_o,
	output fix_pkg::rcv_val_t      rcv_o,
	output cksum_cfg_pkg::status_e status_o,
	input  logic                   res_ack_i
);
	import cksum_cfg_pkg::*;

	lane_byte_if   byte_if [LANES] ();
	lane_result_if res_if  [LANES] ();

	msg_dispatch i_dispatch (
		.clk        (clk),
		.rst        (rst),
		.byte_req_i (byte_req_i),
		.sof_i      (sof_i),
		.byte_i     (byte_i),
		.byte_ack_o (byte_ack_o),
		.lane_o     (byte_if)
	);

	////////////////////////////////////////////////////////////
	// Checksum lanes
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		cksum_lane i_lane (
			.clk     (clk),
			.rst     (rst),
			.byte_in (byte_if[g]),
			.res_out (res_if[g])
		);
	end

	result_collect i_collect (
		.clk       (clk),
		.rst       (rst),
		.lane_i    (res_if),
		.res_ack_i (res_ack_i),
		.res_req_o (res_req_o),
		.cksum_o   (cksum_o),
		.rcv_o     (rcv_o),
		.status_o  (status_o)
	);

endmodule

`default_nettype wire

/* tests/tb_checker.sv */
// Checksum testbench checker
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   byte_req_i,
	input  logic                   byte_ack_i,
	input  logic                   sof_i,
	input  fix_pkg::byte_t         byte_i,
	input  logic                   res_req_i,
	input  logic                   res_ack_i,
	input  fix_pkg::cksum_t        cksum_i,
	input  fix_pkg::rcv_val_t      rcv_i,
	input  cksum_cfg_pkg::status_e status_i,
	output int                     pass_cnt_o,
	output int                     fail_cnt_o,
	output int                     res_cnt_o
);
	import fix_pkg::*;
	import cksum_cfg_pkg::*;

	typedef enum logic [1:0] {
		M_OFF,		// Outside a message, bytes are ignored
		M_BODY,
		M_DIGITS,
		M_TERM
	} model_state_e;

	typedef struct packed {
		logic [31:0] id;
		cksum_t      cksum;
		rcv_val_t    rcv;
		status_e     status;
	} expect_t;

	expect_t      exp_q [$];	// Oldest message first
	byte_t        msg_bytes [$];
	model_state_e m_state;
	cksum_t       m_sum;
	rcv_val_t     m_rcv;
	int           m_digits;
	int           msg_id;
	logic         seen_req;
	logic         idle_bad;	// An output rose before any input

	initial begin
		m_state    = M_OFF;
		msg_id     = 0;
		seen_req   = 1'b0;
		idle_bad   = 1'b0;
		pass_cnt_o = 0;
		fail_cnt_o = 0;
		res_cnt_o  = 0;
	end

	function automatic string status_text(input status_e s);
		case (s)
			OK:         return "OK";
			BAD_SUM:    return "BAD_SUM";
			BAD_FORMAT: return "BAD_FORMAT";
			default:    return "unknown";
		endcase
	endfunction

	task automatic push_expect(input status_e st);
		expect_t e;
		e.id     = msg_id;
		e.cksum  = m_sum;
		e.rcv    = m_rcv;
		e.status = st;
		exp_q.push_back(e);
		msg_id++;
		m_state = M_OFF;
	endtask

	////////////////////////////////////////////////////////////
	// Reference model, one accepted byte at a time
	////////////////////////////////////////////////////////////

	task automatic model_byte(input byte_t b, input logic s);
		int n;
		int i;
		if (s) begin
			msg_bytes.delete();
			m_state = M_BODY;
		end
		case (m_state)
			M_BODY: begin
				msg_bytes.push_back(b);
				n = msg_bytes.size();
				if (n >= 4 && msg_bytes[n-4] == SOH_CHAR && msg_bytes[n-3] == TAG_ONE &&
				    msg_bytes[n-2] == TAG_ZERO && msg_bytes[n-1] == TAG_EQ) begin
					m_sum = '0;
					for (i = 0; i <= n - 4; i++)
						m_sum = m_sum + msg_bytes[i];	// Up to the trailer SOH
					m_rcv    = '0;
					m_digits = 0;
					m_state  = M_DIGITS;
				end
			end
			M_DIGITS: begin
				if (b >= ZERO_CHAR && b <= ZERO_CHAR + 8'd9) begin
					m_rcv = m_rcv * 10 + rcv_val_t'(b - ZERO_CHAR);
					m_digits++;
					if (m_digits == CKSUM_DIGITS)
						m_state = M_TERM;
				end else begin
					push_expect(BAD_FORMAT);	// Rest of the message is ignored
				end
			end
			M_TERM: begin
				if (b != SOH_CHAR)
					push_expect(BAD_FORMAT);
				else if (m_rcv != rcv_val_t'(m_sum))
					push_expect(BAD_SUM);
				else
					push_expect(OK);
			end
			default: ;
		endcase
	endtask

	task automatic check_result();
		expect_t e;
		logic    ok;
		res_cnt_o++;
		if (exp_q.size() == 0) begin
			$display("Error: a result arrived while no message was pending (cksum %h)", cksum_i);
			fail_cnt_o++;
		end else begin
			e  = exp_q.pop_front();
			ok = 1'b1;
			if (cksum_i !== e.cksum) begin
				$display("Mismatch msg %0d cksum_o: got %h, expected %h", e.id, cksum_i, e.cksum);
				ok = 1'b0;
			end
			if (rcv_i !== e.rcv) begin
				$display("Mismatch msg %0d rcv_o: got %h, expected %h", e.id, rcv_i, e.rcv);
				ok = 1'b0;
			end
			if (status_i !== e.status) begin
				$display("Mismatch msg %0d status_o: got %h, expected %h",
				         e.id, status_i, e.status);
				ok = 1'b0;
			end
			$display("Message %0d %s: %s", e.id, status_text(e.status), ok ? "pass" : "fail");
			if (ok)
				pass_cnt_o++;
			else
				fail_cnt_o++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Port monitor, sampled mid-cycle
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!rst) begin
			if (!seen_req) begin
				if (byte_ack_i !== 1'b0 || res_req_i !== 1'b0)
					idle_bad = 1'b1;
				if (byte_req_i) begin
					seen_req = 1'b1;
					if (idle_bad) begin
						$display("Error: byte_ack_o or res_req_o left low state before any input");
						fail_cnt_o++;
					end else begin
						pass_cnt_o++;
					end
					$display("Idle after reset: %s", idle_bad ? "fail" : "pass");
				end
			end
			if (byte_req_i && byte_ack_i)
				model_byte(byte_i, sof_i);
			if (res_req_i && res_ack_i)
				check_result();
		end
	end

	task automatic report_summary();
		if (exp_q.size() != 0) begin
			$display("Error: %0d messages produced no result", exp_q.size());
			fail_cnt_o += exp_q.size();
		end
		$display("Tests passed: %0d, failed: %0d", pass_cnt_o, fail_cnt_o);
	endtask

endmodule

`default_nettype wire

/* tests/tb_top.sv */
// Checksum subsystem testbench
`timescale 1ns/1ns
`default_nettype none

module tb_top;
	import fix_pkg::*;
	import cksum_cfg_pkg::*;

	localparam int          NUM_MSGS       = 60;
	localparam int          TIMEOUT_CYCLES = NUM_MSGS * 30 * 40;
	localparam logic [31:0] SEED           = 32'hede51cb9;

	logic        clk;
	logic        rst;
	logic        byte_req_i;
	byte_t       byte_i;
	logic        sof_i;
	logic        byte_ack_o;
	logic        res_req_o;
	cksum_t      cksum_o;
	rcv_val_t    rcv_o;
	status_e     status_o;
	logic        res_ack_i;

	int          pass_cnt;
	int          fail_cnt;
	int          res_cnt;
	int          cycle_cnt;
	logic [31:0] src_state;		// Separate streams for source and sink
	logic [31:0] sink_state;
	byte_t       msg_q [$];

	fix_cksum_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.byte_req_i (byte_req_i),
		.byte_i     (byte_i),
		.sof_i      (sof_i),
		.byte_ack_o (byte_ack_o),
		.res_req_o  (res_req_o),
		.cksum_o    (cksum_o),
		.rcv_o      (rcv_o),
		.status_o   (status_o),
		.res_ack_i  (res_ack_i)
	);

	tb_checker i_chk (
		.clk        (clk),
		.rst        (rst),
		.byte_req_i (byte_req_i),
		.byte_ack_i (byte_ack_o),
		.sof_i      (sof_i),
		.byte_i     (byte_i),
		.res_req_i  (res_req_o),
		.res_ack_i  (res_ack_i),
		.cksum_i    (cksum_o),
		.rcv_i      (rcv_o),
		.status_i   (status_o),
		.pass_cnt_o (pass_cnt),
		.fail_cnt_o (fail_cnt),
		.res_cnt_o  (res_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int unsigned src_rand(input int unsigned n);
		src_state = lcg_step(src_state);
		return (src_state >> 8) % n;
	endfunction

	function automatic int unsigned sink_rand(input int unsigned n);
		sink_state = lcg_step(sink_state);
		return (sink_state >> 8) % n;
	endfunction

	// Each wait ends 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Message generator and byte source
	////////////////////////////////////////////////////////////

	task automatic build_message();
		int unsigned target;
		int unsigned kind;
		int unsigned val;
		int unsigned pos;
		byte_t       sum;
		byte_t       dig [3];
		msg_q.delete();
		target = 4 + src_rand(17);
		while (msg_q.size() < target) begin
			if (msg_q.size() != 0)
				msg_q.push_back(SOH_CHAR);
			msg_q.push_back(8'h32 + byte_t'(src_rand(8)));	// Tag '2' to '9'
			msg_q.push_back(TAG_EQ);
			repeat (1 + src_rand(2)) begin
				if (src_rand(2) == 0)
					msg_q.push_back(ZERO_CHAR + byte_t'(src_rand(10)));
				else
					msg_q.push_back(8'h41 + byte_t'(src_rand(26)));	// 'A' to 'Z'
			end
		end
		msg_q.push_back(SOH_CHAR);
		sum = '0;
		foreach (msg_q[i])
			sum = sum + msg_q[i];
		msg_q.push_back(TAG_ONE);
		msg_q.push_back(TAG_ZERO);
		msg_q.push_back(TAG_EQ);

		// 0 puts a letter in the digits, 1 and 2 give a wrong value
		kind = src_rand(10);
		val  = sum;
		if (kind == 1 || kind == 2) begin
			val = src_rand(1000);
			if (val == sum)
				val = (val + 1) % 1000;
		end
		dig[0] = ZERO_CHAR + byte_t'(val / 100);
		dig[1] = ZERO_CHAR + byte_t'((val / 10) % 10);
		dig[2] = ZERO_CHAR + byte_t'(val % 10);
		if (kind == 0) begin
			pos      = src_rand(3);
			dig[pos] = 8'h41 + byte_t'(src_rand(26));
		end
		foreach (dig[i])
			msg_q.push_back(dig[i]);
		msg_q.push_back(SOH_CHAR);
	endtask

	task automatic send_byte(input byte_t b, input logic first);
		wait_cycles(src_rand(4));
		byte_i     = b;
		sof_i      = first;
		byte_req_i = 1'b1;
		while (byte_ack_o !== 1'b1)
			wait_cycles(1);
		wait_cycles(1);	// Req stays up over one edge with ack high
		byte_req_i = 1'b0;
		sof_i      = 1'b0;
		while (byte_ack_o !== 1'b0)
			wait_cycles(1);
	endtask

	initial begin : stimulus
		int k;
		int j;
		rst        = 1'b1;
		byte_req_i = 1'b0;
		byte_i     = '0;
		sof_i      = 1'b0;
		res_ack_i  = 1'b0;
		src_state  = SEED;
		sink_state = ~SEED;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		wait_cycles(10);	// Quiet period before any input

		for (k = 0; k < 3; k++)
			send_byte(8'h58, 1'b0);	// Stray bytes ahead of the first start flag

		for (k = 0; k < NUM_MSGS; k++) begin
			build_message();
			for (j = 0; j < msg_q.size(); j++)
				send_byte(msg_q[j], j == 0);
		end

		while (res_cnt < NUM_MSGS)
			wait_cycles(1);
		wait_cycles(50);	// Room for an extra result to show up
		i_chk.report_summary();
		if (fail_cnt == 0 && pass_cnt == NUM_MSGS + 1)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Result sink with random acknowledge delays
	initial begin : sink
		forever begin
			while (res_req_o !== 1'b1)
				wait_cycles(1);
			wait_cycles(sink_rand(31));
			res_ack_i = 1'b1;
			while (res_req_o !== 1'b0)
				wait_cycles(1);
			res_ack_i = 1'b0;
		end
	end

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Error: run stopped after %0d cycles with %0d of %0d results seen",
		         cycle_cnt, res_cnt, NUM_MSGS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
common/fix_pkg.sv
common/cksum_cfg_pkg.sv
common/lane_ifs.sv
rtl/msg_dispatch.sv
cksum_lane/ascii_dec_field.sv
cksum_lane/cksum_lane.sv
rtl/result_collect.sv
rtl/fix_cksum_top.sv
tests/tb_checker.sv
tests/tb_top.sv
